/* flist.f */
src/csr_pkg.sv
src/csr_arbiter.sv
src/irq_capture.sv
src/machine_timer.sv
src/csr_file.sv
src/trap_csr_top.sv
test/trap_csr_props.sv
test/tb_trap_csr.sv

/* run.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_trap_csr -f flist.f -o sim_tb

out=$(./obj_dir/sim_tb +verilator+error+limit+100 || true)
echo "$out"

if grep -q "^RESULT: PASS$" <<< "$out"; then
    exit 0
else
    exit 1
fi

/* test/tb_trap_csr.sv */
// ----------------------------------------
// core port runs directed accesses, dbg adds random traffic
// mtimecmp stays all ones except in the timer test
// ----------------------------------------
`timescale 1ns/100ps

module tb_trap_csr;
    import csr_pkg::*;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] inst_cur;
    logic [31:0] exception_code;
    logic        exception_en;
    logic        branch_hazard;
    logic        jmp_en;
    logic [31:0] jmp_pc;
    logic        peripheral_int;
    logic [7:0]  peripheral_int_code;
    logic        soft_int;
    logic [7:0]  soft_int_code;
    logic [7:0]  cur_int_code;
    logic [31:0] mtimecmp_low;
    logic [31:0] mtimecmp_high;
    logic [31:0] mtime_low;
    logic [31:0] mtime_high;
    logic        core_req_valid;
    logic        core_req_write;
    logic [11:0] core_req_addr;
    logic [31:0] core_req_wdata;
    logic        core_credit;
    logic        core_rsp_valid;
    logic [31:0] core_rsp_rdata;
    logic        dbg_req_valid;
    logic        dbg_req_write;
    logic [11:0] dbg_req_addr;
    logic [31:0] dbg_req_wdata;
    logic        dbg_credit;
    logic        dbg_rsp_valid;
    logic [31:0] dbg_rsp_rdata;

    int          seed = 87;
    int          checks;
    int          errors;
    logic [31:0] rdata;
    cause_u      cause;
    logic [63:0] t_prev;
    logic [63:0] t_start;

    trap_csr_top u_dut (.*);

    bind trap_csr_top trap_csr_props u_props (
        .clk, .rst,
        .core_req_valid, .core_credit, .core_rsp_valid,
        .dbg_req_valid, .dbg_credit, .dbg_rsp_valid,
        .branch_hazard, .jmp_en
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors + 1, u_dut.u_props.fail_count);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic drive_port(input int port, input logic v, input logic w,
                              input logic [11:0] a, input logic [31:0] d);
        if (port == 0) begin
            core_req_valid = v;
            core_req_write = w;
            core_req_addr  = a;
            core_req_wdata = d;
        end else begin
            dbg_req_valid = v;
            dbg_req_write = w;
            dbg_req_addr  = a;
            dbg_req_wdata = d;
        end
    endtask

    // one access on the core port, waits for its response
    task automatic csr_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wd, output logic [31:0] rd);
        int cycles;
        @(negedge clk);
        drive_port(0, 1'b1, wr, addr, wd);
        @(negedge clk);
        drive_port(0, 1'b0, 1'b0, 12'd0, 32'd0);
        cycles = 1;
        while (!core_rsp_valid && cycles < 50) begin
            @(negedge clk);
            cycles++;
        end
        if (!core_rsp_valid) abort_run("no core_rsp_valid after a CSR request");
        else rd = core_rsp_rdata;
    endtask

    task automatic wait_for_jump(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!jmp_en && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (!jmp_en) abort_run({"no jmp_en for the ", what});
    endtask

    // credit-limited stream on one port, each port owns one register
    task automatic traffic(input int port, input int n_ops, input logic [31:0] start);
        logic [31:0] expect_q [$];
        logic [31:0] model;
        logic [31:0] wd;
        logic [31:0] rd;
        logic [11:0] addr;
        logic        rv;
        logic        cr;
        logic        wr;
        logic        go;
        int          credits;
        int          issued;
        int          cycles;
        model   = start;
        credits = CREDITS;
        issued  = 0;
        cycles  = 0;
        addr    = (port == 0) ? ADDR_MSCRATCH : ADDR_MTVAL;
        while (issued < n_ops || expect_q.size() > 0) begin
            @(negedge clk);
            cycles++;
            rv = (port == 0) ? core_rsp_valid : dbg_rsp_valid;
            cr = (port == 0) ? core_credit : dbg_credit;
            rd = (port == 0) ? core_rsp_rdata : dbg_rsp_rdata;
            if (cycles > 400) begin
                abort_run("responses missing in the shared port traffic");
            end else begin
                if (rv && expect_q.size() == 0) begin
                    errors++;
                    $display("port %0d gave a response with nothing outstanding", port);
                end else if (rv) begin
                    check_value((port == 0) ? "core_rsp_rdata" : "dbg_rsp_rdata",
                                rd, expect_q.pop_front());
                end
                if (cr) credits++;
                if (port == 0) go = (cycles % 3) != 0;  // bursts of two
                else go = ($random(seed) & 3) != 0;
                go = go && (issued < n_ops) && (credits > 0);
                wr = (port == 0) ? (issued % 2 == 0) : ($random(seed) & 1);
                wd = (port == 0) ? 32'h1000_0000 + issued * 17 : $random(seed);
                if (go) begin
                    expect_q.push_back(model);  // read value before the write
                    if (wr) model = wd;
                    credits--;
                    issued++;
                end
                drive_port(port, go, wr, addr, wd);
            end
        end
        check_value((port == 0) ? "core credits" : "dbg credits", credits, CREDITS);
    endtask

    initial begin
        rst                 = 1'b0;
        pc                  = 32'd0;
        pc_next             = 32'd0;
        inst_cur            = 32'd0;
        exception_code      = 32'd0;
        exception_en        = 1'b0;
        branch_hazard       = 1'b0;
        peripheral_int      = 1'b0;
        peripheral_int_code = 8'd0;
        soft_int            = 1'b0;
        soft_int_code       = 8'd0;
        mtimecmp_low        = 32'hFFFF_FFFF;
        mtimecmp_high       = 32'hFFFF_FFFF;
        drive_port(0, 1'b0, 1'b0, 12'd0, 32'd0);
        drive_port(1, 1'b0, 1'b0, 12'd0, 32'd0);
        checks = 0;
        errors = 0;
        repeat (2) @(negedge clk);
        rst = 1'b1;

        // plain accesses, writes answer with the old value
        csr_access(1'b1, ADDR_MSCRATCH, 32'hA5A5_1234, rdata);
        check_value("mscratch before write", rdata, 32'd0);
        csr_access(1'b0, ADDR_MSCRATCH, 32'd0, rdata);
        check_value("mscratch", rdata, 32'hA5A5_1234);
        csr_access(1'b1, ADDR_MTVEC, 32'h0000_1001, rdata);
        csr_access(1'b0, ADDR_MTVEC, 32'd0, rdata);
        check_value("mtvec", rdata, 32'h0000_1001);
        csr_access(1'b1, ADDR_MIE, 32'h0000_0888, rdata);
        csr_access(1'b0, ADDR_MIE, 32'd0, rdata);
        check_value("mie", rdata, 32'h0000_0888);
        csr_access(1'b1, ADDR_MISA, 32'hFFFF_FFFF, rdata);
        csr_access(1'b0, ADDR_MISA, 32'd0, rdata);
        check_value("misa", rdata, MISA_VALUE);
        csr_access(1'b1, ADDR_MHARTID, 32'h0000_0005, rdata);
        csr_access(1'b0, ADDR_MHARTID, 32'd0, rdata);
        check_value("mhartid", rdata, MHARTID_VALUE);
        csr_access(1'b0, ADDR_MVENDORID, 32'd0, rdata);
        check_value("mvendorid", rdata, MVENDORID_VALUE);
        csr_access(1'b0, ADDR_MARCHID, 32'd0, rdata);
        check_value("marchid", rdata, MARCHID_VALUE);
        csr_access(1'b0, ADDR_MIMPID, 32'd0, rdata);
        check_value("mimpid", rdata, MIMPID_VALUE);
        csr_access(1'b0, 12'h7C0, 32'd0, rdata);
        check_value("unimplemented CSR", rdata, 32'd0);

        // both ports at once under credit flow
        fork
            traffic(0, 24, 32'hA5A5_1234);
            traffic(1, 24, 32'd0);
        join

        // synchronous exception, MIE was set before
        csr_access(1'b1, ADDR_MSTATUS, 32'h0000_0008, rdata);
        pc             = 32'h0000_0100;
        pc_next        = 32'h0000_0104;
        inst_cur       = 32'hDEAD_0073;
        exception_code = 32'd2;
        exception_en   = 1'b1;
        wait_for_jump("exception");
        exception_en = 1'b0;
        check_value("jmp_pc", jmp_pc, 32'h0000_1000);  // base, mode bits cleared
        csr_access(1'b0, ADDR_MEPC, 32'd0, rdata);
        check_value("mepc", rdata, 32'h0000_0100);
        csr_access(1'b0, ADDR_MCAUSE, 32'd0, rdata);
        check_value("mcause", rdata, 32'd2);
        csr_access(1'b0, ADDR_MTVAL, 32'd0, rdata);
        check_value("mtval", rdata, 32'hDEAD_0073);
        csr_access(1'b0, ADDR_MSTATUS, 32'd0, rdata);
        check_value("mstatus.MIE", rdata[MIE_BIT], 1'b0);
        check_value("mstatus.MPIE", rdata[MPIE_BIT], 1'b1);

        // external and soft together, vectored mtvec
        csr_access(1'b1, ADDR_MIE, 32'h0000_0808, rdata);
        csr_access(1'b1, ADDR_MSTATUS, 32'h0000_0008, rdata);
        pc                  = 32'h0000_0200;
        pc_next             = 32'h0000_0204;
        peripheral_int      = 1'b1;
        peripheral_int_code = 8'h5A;
        soft_int            = 1'b1;
        soft_int_code       = 8'h33;
        wait_for_jump("external interrupt");
        peripheral_int = 1'b0;
        soft_int       = 1'b0;
        check_value("jmp_pc", jmp_pc, 32'h0000_102C);  // base + 4 * 11
        check_value("cur_int_code", cur_int_code, 8'h5A);
        csr_access(1'b0, ADDR_MCAUSE, 32'd0, rdata);
        cause.raw = rdata;
        check_value("mcause.irq", cause.split.irq, 1'b1);
        check_value("mcause.code", cause.split.code, 31'd11);
        csr_access(1'b0, ADDR_MEPC, 32'd0, rdata);
        check_value("mepc", rdata, 32'h0000_0204);
        csr_access(1'b1, ADDR_MSTATUS, 32'h0000_0008, rdata);  // soft still pending
        wait_for_jump("soft interrupt");
        check_value("jmp_pc", jmp_pc, 32'h0000_100C);
        check_value("cur_int_code", cur_int_code, 8'h33);

        // mtime steps by one per cycle
        t_prev  = {mtime_high, mtime_low};
        t_start = t_prev;
        repeat (10) begin
            @(negedge clk);
            check_value("mtime", {mtime_high, mtime_low}, t_prev + 64'd1);
            t_prev = {mtime_high, mtime_low};
        end
        check_value("mtime elapsed", {mtime_high, mtime_low} - t_start, 64'd10);

        // timer trap held off by the hazard
        csr_access(1'b1, ADDR_MIE, 32'h0000_0080, rdata);
        branch_hazard = 1'b1;
        csr_access(1'b1, ADDR_MSTATUS, 32'h0000_0008, rdata);
        t_prev = {mtime_high, mtime_low} + 64'd4;
        {mtimecmp_high, mtimecmp_low} = t_prev;
        repeat (12) begin
            @(negedge clk);
            check_value("jmp_en", jmp_en, 1'b0);
        end
        branch_hazard = 1'b0;
        wait_for_jump("timer interrupt");
        check_value("jmp_pc", jmp_pc, 32'h0000_101C);
        check_value("cur_int_code", cur_int_code, 8'd7);
        csr_access(1'b0, ADDR_MCAUSE, 32'd0, rdata);
        cause.raw = rdata;
        check_value("mcause.irq", cause.split.irq, 1'b1);
        check_value("mcause.code", cause.split.code, 31'd7);
        mtimecmp_low  = 32'hFFFF_FFFF;
        mtimecmp_high = 32'hFFFF_FFFF;

        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* test/trap_csr_props.sv */
// ----------------------------------------
// outstanding counts are rebuilt from the port handshakes
// ----------------------------------------
`timescale 1ns/100ps

module trap_csr_props (
    input logic clk,
    input logic rst,
    input logic core_req_valid,
    input logic core_credit,
    input logic core_rsp_valid,
    input logic dbg_req_valid,
    input logic dbg_credit,
    input logic dbg_rsp_valid,
    input logic branch_hazard,
    input logic jmp_en
);
    import csr_pkg::*;

    int core_out;        // requests not yet credited back
    int dbg_out;
    int fail_count = 0;  // failed assertions so far

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            core_out <= 0;
            dbg_out  <= 0;
        end else begin
            core_out <= core_out + int'(core_req_valid) - int'(core_credit);
            dbg_out  <= dbg_out + int'(dbg_req_valid) - int'(dbg_credit);
        end
    end

    core_in_credit: assert property (@(posedge clk) disable iff (!rst) core_out <= CREDITS)
        else begin
            $error("core port has more requests outstanding than credits");
            fail_count++;
        end

    dbg_in_credit: assert property (@(posedge clk) disable iff (!rst) dbg_out <= CREDITS)
        else begin
            $error("dbg port has more requests outstanding than credits");
            fail_count++;
        end

    core_credit_rsp: assert property (@(posedge clk) disable iff (!rst)
        core_credit |-> core_rsp_valid)
        else begin
            $error("core credit pulse without rsp_valid");
            fail_count++;
        end

    dbg_credit_rsp: assert property (@(posedge clk) disable iff (!rst)
        dbg_credit |-> dbg_rsp_valid)
        else begin
            $error("dbg credit pulse without rsp_valid");
            fail_count++;
        end

    jmp_single: assert property (@(posedge clk) disable iff (!rst) jmp_en |=> !jmp_en)
        else begin
            $error("jmp_en high for two cycles");
            fail_count++;
        end

    jmp_after_hazard: assert property (@(posedge clk) disable iff (!rst)
        branch_hazard |=> !jmp_en)
        else begin
            $error("jmp_en right after a branch hazard cycle");
            fail_count++;
        end

endmodule

/* src/trap_csr_top.sv */
// --------------------------------------
// mtimecmp is an input, mtime runs on clk
// --------------------------------------
`timescale 1ns/100ps

module trap_csr_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    input  logic [31:0] pc_next,
    input  logic [31:0] inst_cur,
    input  logic [31:0] exception_code,
    input  logic        exception_en,
    input  logic        branch_hazard,
    output logic        jmp_en,
    output logic [31:0] jmp_pc,
    input  logic        peripheral_int,
    input  logic [7:0]  peripheral_int_code,
    input  logic        soft_int,
    input  logic [7:0]  soft_int_code,
    output logic [7:0]  cur_int_code,
    input  logic [31:0] mtimecmp_low,
    input  logic [31:0] mtimecmp_high,
    output logic [31:0] mtime_low,
    output logic [31:0] mtime_high,
    input  logic        core_req_valid,
    input  logic        core_req_write,
    input  logic [11:0] core_req_addr,
    input  logic [31:0] core_req_wdata,
    output logic        core_credit,
    output logic        core_rsp_valid,
    output logic [31:0] core_rsp_rdata,
    input  logic        dbg_req_valid,
    input  logic        dbg_req_write,
    input  logic [11:0] dbg_req_addr,
    input  logic [31:0] dbg_req_wdata,
    output logic        dbg_credit,
    output logic        dbg_rsp_valid,
    output logic [31:0] dbg_rsp_rdata
);

    logic        bus_valid, bus_write, bus_ready;
    logic [11:0] bus_addr;
    logic [31:0] bus_wdata, bus_rdata;
    logic        ext_pending, soft_pending, timer_pending;
    logic [7:0]  int_code;
    logic        trap_irq_taken;
    logic [1:0]  trap_src;

    csr_arbiter u_arbiter (
        .clk, .rst,
        .core_req_valid, .core_req_write, .core_req_addr, .core_req_wdata,
        .core_credit, .core_rsp_valid, .core_rsp_rdata,
        .dbg_req_valid, .dbg_req_write, .dbg_req_addr, .dbg_req_wdata,
        .dbg_credit, .dbg_rsp_valid, .dbg_rsp_rdata,
        .bus_valid, .bus_write, .bus_addr, .bus_wdata, .bus_ready, .bus_rdata
    );

    csr_file u_csr_file (
        .clk, .rst,
        .pc, .pc_next, .inst_cur, .exception_code, .exception_en, .branch_hazard,
        .bus_valid, .bus_write, .bus_addr, .bus_wdata, .bus_ready, .bus_rdata,
        .ext_pending, .soft_pending, .timer_pending, .int_code,
        .trap_irq_taken, .trap_src, .jmp_en, .jmp_pc, .cur_int_code
    );

    irq_capture u_irq_capture (
        .clk, .rst,
        .peripheral_int, .peripheral_int_code, .soft_int, .soft_int_code,
        .trap_irq_taken, .trap_src,
        .ext_pending, .soft_pending, .int_code
    );

    machine_timer u_machine_timer (
        .clk, .rst,
        .mtimecmp_low, .mtimecmp_high,
        .mtime_low, .mtime_high, .timer_pending
    );

endmodule

/* src/csr_file.sv */
// --------------------------------------
// no mret, traps only enter; one trap per redirect cycle
// exceptions win over interrupts, ext > soft > timer
// --------------------------------------
`timescale 1ns/100ps

module csr_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    input  logic [31:0] pc_next,
    input  logic [31:0] inst_cur,
    input  logic [31:0] exception_code,
    input  logic        exception_en,
    input  logic        branch_hazard,
    input  logic        bus_valid,
    input  logic        bus_write,
    input  logic [11:0] bus_addr,
    input  logic [31:0] bus_wdata,
    output logic        bus_ready,
    output logic [31:0] bus_rdata,
    input  logic        ext_pending,
    input  logic        soft_pending,
    input  logic        timer_pending,
    input  logic [7:0]  int_code,
    output logic        trap_irq_taken,
    output logic [1:0]  trap_src,
    output logic        jmp_en,
    output logic [31:0] jmp_pc,
    output logic [7:0]  cur_int_code
);
    import csr_pkg::*;

    logic [31:0] mstatus;
    logic [31:0] mie;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] mip_view;
    logic        irq_ext;
    logic        irq_soft;
    logic        irq_timer;
    logic        irq_any;
    logic        take_trap;
    logic        csr_wr;
    cause_u      trap_cause;
    logic [31:0] vec_base;
    logic [31:0] trap_target;

    // pending bits come straight from hardware
    always_comb begin
        mip_view           = 32'd0;
        mip_view[MEIP_BIT] = ext_pending;
        mip_view[MSIP_BIT] = soft_pending;
        mip_view[MTIP_BIT] = timer_pending;
    end

    assign irq_ext   = mstatus[MIE_BIT] & mie[MEIP_BIT] & ext_pending;
    assign irq_soft  = mstatus[MIE_BIT] & mie[MSIP_BIT] & soft_pending & ~irq_ext;
    assign irq_timer = mstatus[MIE_BIT] & mie[MTIP_BIT] & timer_pending
                       & ~irq_ext & ~irq_soft;
    assign irq_any   = irq_ext | irq_soft | irq_timer;

    // jmp_en high means the core is redirecting this cycle
    assign take_trap      = (exception_en | irq_any) & ~branch_hazard & ~jmp_en;
    assign trap_irq_taken = take_trap & ~exception_en;
    assign trap_src       = irq_ext ? SRC_EXT : (irq_soft ? SRC_SOFT : SRC_TIMER);

    assign bus_ready = ~take_trap; // trap owns the CSRs this cycle
    assign csr_wr    = bus_valid & bus_ready & bus_write;

    always_comb begin
        if (exception_en) begin
            trap_cause.raw = exception_code;
        end else begin
            trap_cause.split.irq = 1'b1;
            if (irq_ext) trap_cause.split.code = CAUSE_EXT;
            else if (irq_soft) trap_cause.split.code = CAUSE_SOFT;
            else trap_cause.split.code = CAUSE_TIMER;
        end
    end

    // vectored offset only for interrupts in mode 1
    assign vec_base    = {mtvec[31:2], 2'b00};
    assign trap_target = (!exception_en && mtvec[1:0] == 2'b01)
                         ? vec_base + {trap_cause.split.code[29:0], 2'b00}
                         : vec_base;

    always_comb begin
        case (bus_addr)
            ADDR_MSTATUS:   bus_rdata = mstatus;
            ADDR_MISA:      bus_rdata = MISA_VALUE;
            ADDR_MIE:       bus_rdata = mie;
            ADDR_MTVEC:     bus_rdata = mtvec;
            ADDR_MSCRATCH:  bus_rdata = mscratch;
            ADDR_MEPC:      bus_rdata = mepc;
            ADDR_MCAUSE:    bus_rdata = mcause;
            ADDR_MTVAL:     bus_rdata = mtval;
            ADDR_MIP:       bus_rdata = mip_view;
            ADDR_MVENDORID: bus_rdata = MVENDORID_VALUE;
            ADDR_MARCHID:   bus_rdata = MARCHID_VALUE;
            ADDR_MIMPID:    bus_rdata = MIMPID_VALUE;
            ADDR_MHARTID:   bus_rdata = MHARTID_VALUE;
            default:        bus_rdata = 32'd0; // unimplemented
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mstatus  <= 32'd0;
            mie      <= 32'd0;
            mtvec    <= 32'd0;
            mscratch <= 32'd0;
            mepc     <= 32'd0;
            mcause   <= 32'd0;
            mtval    <= 32'd0;
            jmp_en   <= 1'b0;
        end else begin
            jmp_en <= take_trap;
            if (take_trap) begin
                mstatus[MPIE_BIT] <= mstatus[MIE_BIT];
                mstatus[MIE_BIT]  <= 1'b0;
                mepc              <= exception_en ? pc : pc_next;
                mcause            <= trap_cause.raw;
                if (exception_en) mtval <= inst_cur;
            end else if (csr_wr) begin
                case (bus_addr)
                    ADDR_MSTATUS:  mstatus  <= bus_wdata;
                    ADDR_MIE:      mie      <= bus_wdata;
                    ADDR_MTVEC:    mtvec    <= bus_wdata;
                    ADDR_MSCRATCH: mscratch <= bus_wdata;
                    ADDR_MEPC:     mepc     <= bus_wdata;
                    ADDR_MCAUSE:   mcause   <= bus_wdata;
                    ADDR_MTVAL:    mtval    <= bus_wdata;
                    default: ;     // read-only, mip and unimplemented
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_trap) jmp_pc <= trap_target;
        if (trap_irq_taken) begin
            cur_int_code <= irq_timer ? CAUSE_TIMER[7:0] : int_code;
        end
    end

endmodule

/* src/machine_timer.sv */
// --------------------------------------
// mtime counts on clk, compare is registered one cycle
// --------------------------------------
`timescale 1ns/100ps

module machine_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] mtimecmp_low,
    input  logic [31:0] mtimecmp_high,
    output logic [31:0] mtime_low,
    output logic [31:0] mtime_high,
    output logic        timer_pending
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        reached;

    assign mtimecmp = {mtimecmp_high, mtimecmp_low};
    assign reached  = (mtime >= mtimecmp);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mtime <= 64'd0;
        end else begin
            mtime <= mtime + 64'd1; // free running, wraps
        end
    end

    // level stays high until mtimecmp is moved past mtime
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            timer_pending <= 1'b0;
        end else begin
            timer_pending <= reached;
        end
    end

    assign mtime_low  = mtime[31:0];
    assign mtime_high = mtime[63:32];

endmodule

/* src/irq_capture.sv */
// --------------------------------------
// interrupt lines are sampled on clk, a rise sets pending
// --------------------------------------
`timescale 1ns/100ps

module irq_capture (
    input  logic       clk,
    input  logic       rst,
    input  logic       peripheral_int,
    input  logic [7:0] peripheral_int_code,
    input  logic       soft_int,
    input  logic [7:0] soft_int_code,
    input  logic       trap_irq_taken,
    input  logic [1:0] trap_src,
    output logic       ext_pending,
    output logic       soft_pending,
    output logic [7:0] int_code
);
    import csr_pkg::*;

    logic       ext_prev;
    logic       soft_prev;
    logic       ext_rise;
    logic       soft_rise;
    logic [7:0] ext_code;
    logic [7:0] soft_code;

    assign ext_rise  = peripheral_int & ~ext_prev;
    assign soft_rise = soft_int & ~soft_prev;

    always_ff @(posedge clk) begin
        if (ext_rise) ext_code <= peripheral_int_code;
        if (soft_rise) soft_code <= soft_int_code;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ext_prev     <= 1'b0;
            soft_prev    <= 1'b0;
            ext_pending  <= 1'b0;
            soft_pending <= 1'b0;
        end else begin
            ext_prev  <= peripheral_int;
            soft_prev <= soft_int;
            // a new rise wins over a clear in the same cycle
            if (ext_rise) ext_pending <= 1'b1;
            else if (trap_irq_taken && trap_src == SRC_EXT) ext_pending <= 1'b0;
            if (soft_rise) soft_pending <= 1'b1;
            else if (trap_irq_taken && trap_src == SRC_SOFT) soft_pending <= 1'b0;
        end
    end

    // external first, matches trap priority
    assign int_code = ext_pending ? ext_code : (soft_pending ? soft_code : 8'd0);

endmodule

/* src/csr_arbiter.sv */
// --------------------------------------
// requesters must respect their credits, no request is refused
// slot depth CREDITS is assumed a power of two
// --------------------------------------
`timescale 1ns/100ps

module csr_arbiter (
    input  logic        clk,
    input  logic        rst,
    input  logic        core_req_valid,
    input  logic        core_req_write,
    input  logic [11:0] core_req_addr,
    input  logic [31:0] core_req_wdata,
    output logic        core_credit,
    output logic        core_rsp_valid,
    output logic [31:0] core_rsp_rdata,
    input  logic        dbg_req_valid,
    input  logic        dbg_req_write,
    input  logic [11:0] dbg_req_addr,
    input  logic [31:0] dbg_req_wdata,
    output logic        dbg_credit,
    output logic        dbg_rsp_valid,
    output logic [31:0] dbg_rsp_rdata,
    output logic        bus_valid,
    output logic        bus_write,
    output logic [11:0] bus_addr,
    output logic [31:0] bus_wdata,
    input  logic        bus_ready,
    input  logic [31:0] bus_rdata
);
    import csr_pkg::*;

    logic                req_v [2];
    logic                req_w [2];
    logic [11:0]         req_a [2];
    logic [31:0]         req_d [2];
    logic                q_w [2][CREDITS];
    logic [11:0]         q_a [2][CREDITS];
    logic [31:0]         q_d [2][CREDITS];
    logic [CREDIT_W-2:0] wr_ptr [2];
    logic [CREDIT_W-2:0] rd_ptr [2];
    logic [CREDIT_W-1:0] count [2];
    logic [1:0]          busy;
    logic                rr_next;   // port served next when both wait
    logic                sel;
    logic                grant;
    logic [1:0]          grant_port;
    logic [1:0]          rsp_v;
    logic [31:0]         rsp_data;

    // port 0 is the core, port 1 the debug host
    assign req_v[0] = core_req_valid;
    assign req_w[0] = core_req_write;
    assign req_a[0] = core_req_addr;
    assign req_d[0] = core_req_wdata;
    assign req_v[1] = dbg_req_valid;
    assign req_w[1] = dbg_req_write;
    assign req_a[1] = dbg_req_addr;
    assign req_d[1] = dbg_req_wdata;

    assign busy[0] = (count[0] != '0);
    assign busy[1] = (count[1] != '0);
    assign sel     = (busy[0] && busy[1]) ? rr_next : busy[1];

    assign bus_valid = |busy;
    assign bus_write = q_w[sel][rd_ptr[sel]];
    assign bus_addr  = q_a[sel][rd_ptr[sel]];
    assign bus_wdata = q_d[sel][rd_ptr[sel]];

    assign grant      = bus_valid & bus_ready;
    assign grant_port = {grant & sel, grant & ~sel};

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (req_v[p]) begin
                q_w[p][wr_ptr[p]] <= req_w[p];
                q_a[p][wr_ptr[p]] <= req_a[p];
                q_d[p][wr_ptr[p]] <= req_d[p];
            end
        end
        if (grant) begin
            rsp_data <= bus_rdata; // value before any write of this access
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int p = 0; p < 2; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
            end
            rr_next <= 1'b0;
            rsp_v   <= 2'b00;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (req_v[p]) begin
                    wr_ptr[p] <= wr_ptr[p] + 1'b1;
                end
                if (grant_port[p]) begin
                    rd_ptr[p] <= rd_ptr[p] + 1'b1;
                end
                if (req_v[p] && !grant_port[p]) begin
                    count[p] <= count[p] + 1'b1;
                end else if (!req_v[p] && grant_port[p]) begin
                    count[p] <= count[p] - 1'b1;
                end
            end
            if (grant) begin
                rr_next <= ~sel;
            end
            rsp_v <= grant_port; // response and credit one cycle after the bus
        end
    end

    assign core_rsp_valid = rsp_v[0];
    assign core_credit    = rsp_v[0];
    assign core_rsp_rdata = rsp_data;
    assign dbg_rsp_valid  = rsp_v[1];
    assign dbg_credit     = rsp_v[1];
    assign dbg_rsp_rdata  = rsp_data;

endmodule

/* src/csr_pkg.sv */
// --------------------------------------
// machine mode only, 32-bit CSR data
// addresses are 12 bits as in the CSR instruction field
// --------------------------------------
package csr_pkg;

    // implemented CSR addresses
    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MISA      = 12'h301;
    localparam logic [11:0] ADDR_MIE       = 12'h304;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] ADDR_MIP       = 12'h344;
    localparam logic [11:0] ADDR_MVENDORID = 12'hF11;
    localparam logic [11:0] ADDR_MARCHID   = 12'hF12;
    localparam logic [11:0] ADDR_MIMPID    = 12'hF13;
    localparam logic [11:0] ADDR_MHARTID   = 12'hF14;

    // read-only values
    localparam logic [31:0] MISA_VALUE      = 32'h4000_0100; // rv32i
    localparam logic [31:0] MVENDORID_VALUE = 32'h0000_0000; // non-commercial
    localparam logic [31:0] MARCHID_VALUE   = 32'h0000_0000;
    localparam logic [31:0] MIMPID_VALUE    = 32'h0000_0001;
    localparam logic [31:0] MHARTID_VALUE   = 32'h0000_0000; // single hart

    // interrupt cause codes
    localparam logic [30:0] CAUSE_EXT   = 31'd11;
    localparam logic [30:0] CAUSE_SOFT  = 31'd3;
    localparam logic [30:0] CAUSE_TIMER = 31'd7;

    // mstatus bits
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    // mie / mip bits
    localparam int MEIP_BIT = 11;
    localparam int MSIP_BIT = 3;
    localparam int MTIP_BIT = 7;

    // interrupt source select reported with a taken trap
    localparam logic [1:0] SRC_EXT   = 2'd0;
    localparam logic [1:0] SRC_SOFT  = 2'd1;
    localparam logic [1:0] SRC_TIMER = 2'd2;

    // request slots per requester port, one per credit
    localparam int CREDITS  = 2;
    localparam int CREDIT_W = 2;

    // mcause word, whole or split into flag and code
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic        irq;
            logic [30:0] code;
        } split;
    } cause_u;

endpackage
